/* alu_sub_pkg.sv */
`default_nettype none

package alu_sub_pkg;

    localparam int DATA_W = 32;

    // Encodings follow the instruction set opcode field
    typedef enum logic [4:0] {
        op_add  = 5'd3,
        op_sub  = 5'd4,
        op_and  = 5'd5,
        op_or   = 5'd6,
        op_shr  = 5'd7,
        op_shra = 5'd8,
        op_shl  = 5'd9,
        op_ror  = 5'd10,
        op_rol  = 5'd11,
        op_addi = 5'd12,
        op_andi = 5'd13,
        op_ori  = 5'd14,
        op_mul  = 5'd15,
        op_div  = 5'd16,
        op_neg  = 5'd17,
        op_not  = 5'd18
    } alu_op_e;

    // One operation from the requester
    typedef struct packed {
        alu_op_e             op;
        logic [DATA_W-1:0]   a;
        logic [DATA_W-1:0]   b;
        logic [15:0]         imm;
    } alu_req_t;

    // HI/LO result with status
    typedef struct packed {
        logic [DATA_W-1:0]   hi;
        logic [DATA_W-1:0]   lo;
        logic                illegal;   // Opcode outside the map
        logic                div_zero;
    } alu_res_t;

endpackage

`default_nettype wire

/* alu_core.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_core (
    input  alu_sub_pkg::alu_op_e           op,
    input  logic [alu_sub_pkg::DATA_W-1:0] a,
    input  logic [alu_sub_pkg::DATA_W-1:0] b,
    input  logic [15:0]                    imm,
    output logic [alu_sub_pkg::DATA_W-1:0] y
);

    localparam int W = alu_sub_pkg::DATA_W;

    logic [4:0]     amt;
    logic [2*W-1:0] a_dbl;
    logic [2*W-1:0] rol_full;
    logic [2*W-1:0] ror_full;
    logic [W-1:0]   imm_sext;
    logic [W-1:0]   imm_zext;

    assign amt      = b[4:0];           // Only the low five bits count
    assign a_dbl    = {a, a};
    assign rol_full = a_dbl << amt;
    assign ror_full = a_dbl >> amt;
    assign imm_sext = {{(W-16){imm[15]}}, imm};
    assign imm_zext = {{(W-16){1'b0}}, imm};

    always_comb begin
        case (op)
            alu_sub_pkg::op_add: begin
                y = a + b;
            end
            alu_sub_pkg::op_sub: begin
                y = a - b;
            end
            alu_sub_pkg::op_and: begin
                y = a & b;
            end
            alu_sub_pkg::op_or: begin
                y = a | b;
            end
            alu_sub_pkg::op_shr: begin
                y = a >> amt;
            end
            alu_sub_pkg::op_shra: begin
                y = $signed(a) >>> amt;
            end
            alu_sub_pkg::op_shl: begin
                y = a << amt;
            end
            alu_sub_pkg::op_ror: begin
                y = ror_full[W-1:0];
            end
            alu_sub_pkg::op_rol: begin
                y = rol_full[2*W-1:W];
            end
            alu_sub_pkg::op_addi: begin
                y = a + imm_sext;
            end
            alu_sub_pkg::op_andi: begin
                y = a & imm_zext;
            end
            alu_sub_pkg::op_ori: begin
                y = a | imm_zext;
            end
            alu_sub_pkg::op_neg: begin
                y = -b;
            end
            alu_sub_pkg::op_not: begin
                y = ~b;
            end
            default: begin
                y = '0;                 // mul, div and illegal codes
            end
        endcase
    end

endmodule

`default_nettype wire

/* mul_div_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_div_unit (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,
    input  logic                           is_div,
    input  logic [alu_sub_pkg::DATA_W-1:0] a,
    input  logic [alu_sub_pkg::DATA_W-1:0] b,
    output logic                           busy,
    output logic                           done,
    output logic [alu_sub_pkg::DATA_W-1:0] hi,
    output logic [alu_sub_pkg::DATA_W-1:0] lo,
    output logic                           div_zero
);

    localparam int W     = alu_sub_pkg::DATA_W;
    localparam int CNT_W = $clog2(W);

    logic [CNT_W-1:0] cnt;
    logic             mode_div;
    logic             neg_q;        // Product sign for mul, quotient sign for div
    logic             neg_r;
    logic [W-1:0]     mag_b;
    logic [W-1:0]     acc_hi;       // Upper product or partial remainder
    logic [W-1:0]     acc_lo;       // Multiplier or dividend/quotient
    logic [W:0]       add_x;
    logic [W:0]       add_y;
    logic [W:0]       add_s;
    logic [2*W-1:0]   prod;

    // One adder serves both, subtracting for the divide step
    always_comb begin
        if (mode_div) begin
            add_x = {acc_hi, acc_lo[W-1]};
            add_y = ~{1'b0, mag_b};
        end else begin
            add_x = {1'b0, acc_hi};
            add_y = acc_lo[0] ? {1'b0, mag_b} : '0;
        end
        add_s = add_x + add_y + {{W{1'b0}}, mode_div};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            done <= 1'b0;
            cnt  <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == CNT_W'(W - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mode_div <= is_div;
            neg_q    <= a[W-1] ^ b[W-1];
            neg_r    <= a[W-1];
            div_zero <= is_div && (b == '0);
            mag_b    <= b[W-1] ? -b : b;
            acc_lo   <= a[W-1] ? -a : a;
            acc_hi   <= '0;
        end else if (busy) begin
            if (mode_div) begin
                // Restore when the trial subtraction goes negative
                acc_hi <= add_s[W] ? add_x[W-1:0] : add_s[W-1:0];
                acc_lo <= {acc_lo[W-2:0], ~add_s[W]};
            end else begin
                {acc_hi, acc_lo} <= {add_s, acc_lo[W-1:1]};
            end
        end
    end

    assign prod = {acc_hi, acc_lo};

    // Divide by zero leaves |a| in the remainder, so hi comes out as a
    always_comb begin
        if (mode_div) begin
            hi = neg_r ? -acc_hi : acc_hi;
            lo = div_zero ? '1 : (neg_q ? -acc_lo : acc_lo);
        end else begin
            {hi, lo} = neg_q ? -prod : prod;
        end
    end

    no_start_busy: assert property (
        @(posedge clk) disable iff (!rst_n) start |-> !busy
    ) else $error("start while busy");

endmodule

`default_nettype wire

/* op_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module op_capture (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req,
    input  alu_sub_pkg::alu_req_t req_data,
    output logic                  ack,
    output logic                  op_valid,
    input  logic                  op_ready,
    output alu_sub_pkg::alu_req_t op_data
);

    logic take;

    // New request only when the slot is free and the last handshake closed
    assign take = req && !ack && !op_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack      <= 1'b0;
            op_valid <= 1'b0;
        end else begin
            if (take) begin
                ack      <= 1'b1;
                op_valid <= 1'b1;
            end else if (op_valid && op_ready) begin
                op_valid <= 1'b0;   // Slot released on transfer
            end
            if (!req) begin
                ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            op_data <= req_data;
        end
    end

    ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n) $rose(ack) |-> req
    ) else $error("ack rose while req low");

    op_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        op_valid && !op_ready |=> op_valid && $stable(op_data)
    ) else $error("op_data changed before transfer");

endmodule

`default_nettype wire

/* alu_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_exec (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  alu_sub_pkg::alu_req_t in_data,
    output logic                  out_valid,
    input  logic                  out_ready,
    output alu_sub_pkg::alu_res_t out_data
);

    logic [alu_sub_pkg::DATA_W-1:0] core_y;
    logic [alu_sub_pkg::DATA_W-1:0] md_hi;
    logic [alu_sub_pkg::DATA_W-1:0] md_lo;
    logic                           md_busy;
    logic                           md_done;
    logic                           md_dz;
    logic                           accept;
    logic                           is_div;
    logic                           is_md;
    logic                           illegal;

    assign is_div   = in_data.op == alu_sub_pkg::op_div;
    assign is_md    = is_div || (in_data.op == alu_sub_pkg::op_mul);
    assign illegal  = !(in_data.op inside {[alu_sub_pkg::op_add : alu_sub_pkg::op_not]});
    assign in_ready = !md_busy && !md_done && !out_valid;
    assign accept   = in_valid && in_ready;

    alu_core u_core (
        .op  (in_data.op),
        .a   (in_data.a),
        .b   (in_data.b),
        .imm (in_data.imm),
        .y   (core_y)
    );

    mul_div_unit u_mul_div (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (accept && is_md),
        .is_div   (is_div),
        .a        (in_data.a),
        .b        (in_data.b),
        .busy     (md_busy),
        .done     (md_done),
        .hi       (md_hi),
        .lo       (md_lo),
        .div_zero (md_dz)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if ((accept && !is_md) || md_done) begin
            out_valid <= 1'b1;
        end else if (out_valid && out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !is_md) begin
            out_data.hi       <= '0;
            out_data.lo       <= core_y;      // Core gives zero for illegal codes
            out_data.illegal  <= illegal;
            out_data.div_zero <= 1'b0;
        end else if (md_done) begin
            out_data.hi       <= md_hi;
            out_data.lo       <= md_lo;
            out_data.illegal  <= 1'b0;
            out_data.div_zero <= md_dz;
        end
    end

endmodule

`default_nettype wire

/* hi_lo_writer.sv */
`timescale 1ns/1ps
`default_nettype none

module hi_lo_writer (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  alu_sub_pkg::alu_res_t in_data,
    output logic                  res_req,
    input  logic                  res_ack,
    output alu_sub_pkg::alu_res_t res_data
);

    logic load;

    // Idle only when both handshake lines are back to zero
    assign in_ready = !res_req && !res_ack;
    assign load     = in_valid && in_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_req <= 1'b0;
        end else if (load) begin
            res_req <= 1'b1;
        end else if (res_ack) begin
            res_req <= 1'b0;
        end
    end

    // HI/LO register
    always_ff @(posedge clk) begin
        if (load) begin
            res_data <= in_data;
        end
    end

    res_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        res_req && !res_ack |=> res_req && $stable(res_data)
    ) else $error("res_req dropped or res_data moved before res_ack");

endmodule

`default_nettype wire

/* alu_sub_top.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_sub_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req,
    input  alu_sub_pkg::alu_req_t req_data,
    output logic                  ack,
    output logic                  res_req,
    input  logic                  res_ack,
    output alu_sub_pkg::alu_res_t res_data
);

    logic                  op_valid;
    logic                  op_ready;
    alu_sub_pkg::alu_req_t op_data;
    logic                  ex_valid;
    logic                  ex_ready;
    alu_sub_pkg::alu_res_t ex_data;

    op_capture u_capture (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .op_valid (op_valid),
        .op_ready (op_ready),
        .op_data  (op_data)
    );

    alu_exec u_exec (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (op_valid),
        .in_ready  (op_ready),
        .in_data   (op_data),
        .out_valid (ex_valid),
        .out_ready (ex_ready),
        .out_data  (ex_data)
    );

    hi_lo_writer u_writer (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (ex_valid),
        .in_ready (ex_ready),
        .in_data  (ex_data),
        .res_req  (res_req),
        .res_ack  (res_ack),
        .res_data (res_data)
    );

endmodule

`default_nettype wire

/* alu_sub_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_sub_tb;

    typedef struct packed {
        logic [4:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] imm;
        logic [31:0] hi;
        logic [31:0] lo;
        logic [1:0]  flags;         // Illegal, then div_zero
    } vec_t;

    logic                  clk;
    logic                  rst_n;
    logic                  req;
    logic                  ack;
    logic                  res_req;
    logic                  res_ack;
    alu_sub_pkg::alu_req_t req_data;
    alu_sub_pkg::alu_res_t res_data;
    alu_sub_pkg::alu_res_t res_data_q;
    logic                  ack_q;
    logic                  res_req_q;
    logic                  res_ack_q;
    logic [31:0]           lfsr;
    vec_t                  vecs[$];
    int                    n_done;
    int                    cycles = 0;

    alu_sub_top u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .res_req  (res_req),
        .res_ack  (res_ack),
        .res_data (res_data)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // Taps 32, 22, 2, 1
    endfunction

    task automatic abort(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [65:0] got, input logic [65:0] exp);
        if (got !== exp) begin
            abort($sformatf("Fail t=%0t %s got=%h exp=%h", $time, name, got, exp));
        end
    endtask

    task automatic add_vec(input logic [4:0] op, input logic [31:0] a, input logic [31:0] b,
                           input logic [15:0] imm, input logic [31:0] hi,
                           input logic [31:0] lo, input logic [1:0] flags);
        vecs.push_back(vec_t'({op, a, b, imm, hi, lo, flags}));
    endtask

    task automatic load_vectors();
        add_vec(alu_sub_pkg::op_add, 32'h5, 32'h7, 16'h0, 32'h0, 32'hC, 2'b00);
        add_vec(alu_sub_pkg::op_add, 32'hFFFFFFFF, 32'h1, 16'h0, 32'h0, 32'h0, 2'b00);
        add_vec(alu_sub_pkg::op_add, 32'h7FFFFFFF, 32'h1, 16'h0, 32'h0, 32'h80000000, 2'b00);
        add_vec(alu_sub_pkg::op_sub, 32'h5, 32'h7, 16'h0, 32'h0, 32'hFFFFFFFE, 2'b00);
        add_vec(alu_sub_pkg::op_sub, 32'h80000000, 32'h1, 16'h0, 32'h0, 32'h7FFFFFFF, 2'b00);
        add_vec(alu_sub_pkg::op_and, 32'hF0F0F0F0, 32'hFF00FF00, 16'h0, 32'h0, 32'hF000F000, 2'b00);
        add_vec(alu_sub_pkg::op_or, 32'hF0F0F0F0, 32'h0F000F00, 16'h0, 32'h0, 32'hFFF0FFF0, 2'b00);
        add_vec(alu_sub_pkg::op_addi, 32'h10, 32'h0, 16'hFFFE, 32'h0, 32'hE, 2'b00);
        add_vec(alu_sub_pkg::op_addi, 32'h0, 32'h0, 16'h8000, 32'h0, 32'hFFFF8000, 2'b00);
        add_vec(alu_sub_pkg::op_andi, 32'hFFFFFFFF, 32'h0, 16'h8001, 32'h0, 32'h8001, 2'b00);
        add_vec(alu_sub_pkg::op_ori, 32'h12340000, 32'h0, 16'hFFFF, 32'h0, 32'h1234FFFF, 2'b00);
        add_vec(alu_sub_pkg::op_mul, 32'h7, 32'h6, 16'h0, 32'h0, 32'h2A, 2'b00);
        add_vec(alu_sub_pkg::op_shr, 32'h80000000, 32'h0, 16'h0, 32'h0, 32'h80000000, 2'b00);
        add_vec(alu_sub_pkg::op_mul, 32'hFFFFFFF9, 32'h6, 16'h0, 32'hFFFFFFFF, 32'hFFFFFFD6, 2'b00);
        add_vec(alu_sub_pkg::op_shr, 32'h80000000, 32'h1, 16'h0, 32'h0, 32'h40000000, 2'b00);
        add_vec(alu_sub_pkg::op_mul, 32'h7, 32'hFFFFFFFA, 16'h0, 32'hFFFFFFFF, 32'hFFFFFFD6, 2'b00);
        add_vec(alu_sub_pkg::op_shr, 32'h80000000, 32'h1F, 16'h0, 32'h0, 32'h1, 2'b00);
        add_vec(alu_sub_pkg::op_shr, 32'hF0000000, 32'hFFFFFFE4, 16'h0, 32'h0, 32'h0F000000, 2'b00);
        add_vec(alu_sub_pkg::op_mul, 32'hFFFFFFF9, 32'hFFFFFFFA, 16'h0, 32'h0, 32'h2A, 2'b00);
        add_vec(alu_sub_pkg::op_shra, 32'h80000000, 32'h0, 16'h0, 32'h0, 32'h80000000, 2'b00);
        add_vec(alu_sub_pkg::op_shra, 32'h80000000, 32'h1, 16'h0, 32'h0, 32'hC0000000, 2'b00);
        add_vec(alu_sub_pkg::op_shra, 32'h80000000, 32'h1F, 16'h0, 32'h0, 32'hFFFFFFFF, 2'b00);
        add_vec(alu_sub_pkg::op_shra, 32'hF0000000, 32'hFFFFFFE4, 16'h0, 32'h0, 32'hFF000000, 2'b00);
        add_vec(alu_sub_pkg::op_mul, 32'h7FFFFFFF, 32'h7FFFFFFF, 16'h0, 32'h3FFFFFFF, 32'h1, 2'b00);
        add_vec(alu_sub_pkg::op_shl, 32'h12345678, 32'h0, 16'h0, 32'h0, 32'h12345678, 2'b00);
        add_vec(alu_sub_pkg::op_shl, 32'h80000001, 32'h1, 16'h0, 32'h0, 32'h2, 2'b00);
        add_vec(alu_sub_pkg::op_shl, 32'h1, 32'h1F, 16'h0, 32'h0, 32'h80000000, 2'b00);
        add_vec(alu_sub_pkg::op_shl, 32'h12345678, 32'h4, 16'h0, 32'h0, 32'h23456780, 2'b00);
        add_vec(alu_sub_pkg::op_shl, 32'h12345678, 32'hFFFFFFE4, 16'h0, 32'h0, 32'h23456780, 2'b00);
        add_vec(alu_sub_pkg::op_mul, 32'h80000000, 32'h80000000, 16'h0, 32'h40000000, 32'h0, 2'b00);
        add_vec(alu_sub_pkg::op_ror, 32'h12345678, 32'h0, 16'h0, 32'h0, 32'h12345678, 2'b00);
        add_vec(alu_sub_pkg::op_ror, 32'h1, 32'h1, 16'h0, 32'h0, 32'h80000000, 2'b00);
        add_vec(alu_sub_pkg::op_ror, 32'h12345678, 32'h1F, 16'h0, 32'h0, 32'h2468ACF0, 2'b00);
        add_vec(alu_sub_pkg::op_ror, 32'h12345678, 32'h8, 16'h0, 32'h0, 32'h78123456, 2'b00);
        add_vec(alu_sub_pkg::op_ror, 32'h12345678, 32'hFFFFFFE4, 16'h0, 32'h0, 32'h81234567, 2'b00);
        add_vec(alu_sub_pkg::op_div, 32'h7, 32'h2, 16'h0, 32'h1, 32'h3, 2'b00);
        add_vec(alu_sub_pkg::op_rol, 32'h12345678, 32'h0, 16'h0, 32'h0, 32'h12345678, 2'b00);
        add_vec(alu_sub_pkg::op_rol, 32'h80000001, 32'h1, 16'h0, 32'h0, 32'h3, 2'b00);
        add_vec(alu_sub_pkg::op_div, 32'hFFFFFFF9, 32'h2, 16'h0, 32'hFFFFFFFF, 32'hFFFFFFFD, 2'b00);
        add_vec(alu_sub_pkg::op_rol, 32'h12345678, 32'h1F, 16'h0, 32'h0, 32'h091A2B3C, 2'b00);
        add_vec(alu_sub_pkg::op_div, 32'h7, 32'hFFFFFFFE, 16'h0, 32'h1, 32'hFFFFFFFD, 2'b00);
        add_vec(alu_sub_pkg::op_rol, 32'h12345678, 32'hFFFFFFE4, 16'h0, 32'h0, 32'h23456781, 2'b00);
        add_vec(alu_sub_pkg::op_div, 32'hFFFFFFF9, 32'hFFFFFFFE, 16'h0, 32'hFFFFFFFF, 32'h3, 2'b00);
        add_vec(alu_sub_pkg::op_neg, 32'hDEADBEEF, 32'h1, 16'h0, 32'h0, 32'hFFFFFFFF, 2'b00);
        add_vec(alu_sub_pkg::op_div, 32'h80000000, 32'hFFFFFFFF, 16'h0, 32'h0, 32'h80000000, 2'b00);
        add_vec(alu_sub_pkg::op_not, 32'h0, 32'h0F0F0F0F, 16'h0, 32'h0, 32'hF0F0F0F0, 2'b00);
        add_vec(alu_sub_pkg::op_div, 32'h64, 32'h0, 16'h0, 32'h64, 32'hFFFFFFFF, 2'b01);
        add_vec(alu_sub_pkg::op_div, 32'hFFFFFFFB, 32'h0, 16'h0, 32'hFFFFFFFB, 32'hFFFFFFFF, 2'b01);
        add_vec(5'd0, 32'h1234, 32'h5678, 16'h9ABC, 32'h0, 32'h0, 2'b10);   // Below the map
        add_vec(5'd31, 32'h1234, 32'h5678, 16'h9ABC, 32'h0, 32'h0, 2'b10);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst_n    = 1'b0;
        req      = 1'b0;
        req_data = '0;
        load_vectors();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("ack", 66'(ack), '0);
        check("res_req", 66'(res_req), '0);
        foreach (vecs[i]) begin
            @(posedge clk);
            req_data <= {vecs[i].op, vecs[i].a, vecs[i].b, vecs[i].imm};
            req      <= 1'b1;
            do @(negedge clk); while (!ack);
            @(posedge clk);
            req <= 1'b0;
            do @(negedge clk); while (ack);     // Four-phase close before the next one
        end
        while (n_done < vecs.size()) begin
            @(posedge clk);
        end
        $display("*** PASSED ***");
        $finish;
    end

    // Consumer with random idle gaps, results checked in request order
    initial begin : consumer
        logic [2:0] gap;
        vec_t       v;
        res_ack = 1'b0;
        lfsr    = 32'h71d55096;
        n_done  = 0;
        @(posedge rst_n);
        while (n_done < vecs.size()) begin
            v = vecs[n_done];
            do @(negedge clk); while (!res_req);
            check($sformatf("res_data[%0d]", n_done), res_data, {v.hi, v.lo, v.flags});
            for (int k = 0; k < 3; k++) begin
                lfsr = lfsr_next(lfsr);
                gap  = {gap[1:0], lfsr[0]};
            end
            repeat (gap) @(posedge clk);
            @(posedge clk);
            res_ack <= 1'b1;
            do @(negedge clk); while (res_req);
            @(posedge clk);
            res_ack <= 1'b0;
            n_done = n_done + 1;
        end
    end

    always @(negedge clk) begin
        if (rst_n) begin
            if (ack && !ack_q) begin
                check("req", 66'(req), 66'(1));
            end
            if (res_req_q && !res_ack_q) begin
                check("res_req", 66'(res_req), 66'(1));
                check("res_data", res_data, res_data_q);
            end
        end
        ack_q      <= ack;
        res_req_q  <= res_req;
        res_ack_q  <= res_ack;
        res_data_q <= res_data;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 60 * vecs.size() + 200) begin
            abort("Timeout: not all results arrived within the cycle limit");
        end
    end

endmodule

`default_nettype wire

/* alu_sub.f */
alu_sub_pkg.sv
alu_core.sv
mul_div_unit.sv
op_capture.sv
alu_exec.sv
hi_lo_writer.sv
alu_sub_top.sv
alu_sub_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= alu_sub_tb
FLIST     ?= alu_sub.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= *** PASSED ***

SRCS := $(shell grep -v '^+' $(FLIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM)
	@out="$$($(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
